//--- common/soundPkg.sv
package soundPkg;

	// Tone period of one voice, counted in prescaled ticks
	typedef logic [9:0] tonePeriodT;

	// Attenuation code, 0 is loudest
	typedef logic [3:0] attenT;

	// Linear amplitude of a single voice
	typedef logic [7:0] amplitudeT;

	// Sum of all voice amplitudes
	// Also sets the width of the sigma-delta accumulator
	typedef logic [9:0] mixLevelT;

	// Bit select of the addressable system latch
	typedef logic [2:0] latchAddrT;

	// Slow data bus byte (system VIA port A)
	typedef logic [7:0] busByteT;

	// Fixed divide ratio of the tone prescaler
	// Held in 5 bits so the counter type can be taken from it
	localparam logic [4:0] prescaleDiv = 5'd16;

	// Attenuation code that mutes a voice
	localparam attenT attenSilent = 4'hF;

endpackage

//--- psg/psgBusInterface.sv
module psgBusInterface #(
	parameter int channelCount = 3
) (
	input  logic                PIXELCLK,
	input  logic                reset,
	input  logic                procEn,
	input  logic                latchWrite,
	input  soundPkg::latchAddrT latchAddress,
	input  logic                latchData,
	input  soundPkg::busByteT   portA,
	output logic                toneTick,
	output logic [channelCount*$bits(soundPkg::tonePeriodT)-1:0] periods,
	output logic [channelCount*$bits(soundPkg::attenT)-1:0]      attens
);

	import soundPkg::*;

	localparam int periodWidth = $bits(tonePeriodT);
	localparam int attenWidth = $bits(attenT);

	// Addressable latch, bit 0 is the sound write-enable (active low)
	logic [7:0] systemLatch;
	logic weDelayed;
	logic soundWrite;

	// Channel and register kind remembered from the last latch byte
	logic [1:0] latchedChannel;
	logic latchedVolume;

	// Target of the current write
	logic [1:0] targetChannel;
	logic targetVolume;

	tonePeriodT periodRegs [channelCount];
	attenT attenRegs [channelCount];

	logic [$bits(prescaleDiv)-1:0] prescaleCount;

	// Latch only takes a bit when the processor is enabled
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			systemLatch <= 8'hFF;
		end else if (latchWrite && procEn) begin
			systemLatch[latchAddress] <= latchData;
		end
	end

	// Falling edge of the write-enable
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			weDelayed <= 1'b1;
		end else begin
			weDelayed <= systemLatch[0];
		end
	end

	assign soundWrite = weDelayed && !systemLatch[0];

	// A latch byte carries its own channel and kind
	// a data byte falls back to the latched ones
	always_comb begin
		if (portA[7]) begin
			targetChannel = portA[6:5];
			targetVolume = portA[4];
		end else begin
			targetChannel = latchedChannel;
			targetVolume = latchedVolume;
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			latchedChannel <= '0;
			latchedVolume <= 1'b0;
		end else if (soundWrite && portA[7]) begin
			latchedChannel <= portA[6:5];
			latchedVolume <= portA[4];
		end
	end

	// Register file, channels at or above channelCount are ignored
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			for (int i = 0; i < channelCount; i++) begin
				periodRegs[i] <= '0;
				attenRegs[i] <= attenSilent;
			end
		end else if (soundWrite) begin
			for (int i = 0; i < channelCount; i++) begin
				if (targetChannel == i) begin
					if (targetVolume) begin
						attenRegs[i] <= portA[3:0];
					end else if (portA[7]) begin
						// Low nibble of the period
						periodRegs[i][3:0] <= portA[3:0];
					end else begin
						// High six bits of the period
						periodRegs[i][9:4] <= portA[5:0];
					end
				end
			end
		end
	end

	always_comb begin
		for (int i = 0; i < channelCount; i++) begin
			periods[i*periodWidth +: periodWidth] = periodRegs[i];
			attens[i*attenWidth +: attenWidth] = attenRegs[i];
		end
	end

	// One tone tick every 16 processor enables
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			prescaleCount <= '0;
			toneTick <= 1'b0;
		end else begin
			toneTick <= 1'b0;
			if (procEn) begin
				if (prescaleCount == prescaleDiv - 1'b1) begin
					prescaleCount <= '0;
					toneTick <= 1'b1;
				end else begin
					prescaleCount <= prescaleCount + 1'b1;
				end
			end
		end
	end

endmodule

//--- psg/toneChannel.sv
module toneChannel (
	input  logic                 PIXELCLK,
	input  logic                 reset,
	input  logic                 toneTick,
	input  soundPkg::tonePeriodT period,
	output logic                 square
);

	import soundPkg::*;

	tonePeriodT count;
	logic expired;

	// A count of 0 or 1 ends the half period
	// so a period of 0 behaves like a period of 1
	assign expired = (count <= tonePeriodT'(1));

	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			count <= '0;
		end else if (toneTick) begin
			if (expired) begin
				count <= period;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// Flip the output on every reload
	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			square <= 1'b0;
		end else if (toneTick && expired) begin
			square <= ~square;
		end
	end

endmodule

//--- psg/psgMixer.sv
module psgMixer #(
	parameter int channelCount = 3
) (
	input  logic                    PIXELCLK,
	input  logic                    reset,
	input  logic [channelCount-1:0] squares,
	input  logic [channelCount*$bits(soundPkg::attenT)-1:0] attens,
	output logic                    pwm
);

	import soundPkg::*;

	localparam int attenWidth = $bits(attenT);
	localparam int levelWidth = $bits(mixLevelT);

	amplitudeT voiceAmp [channelCount];
	mixLevelT levelSum;
	mixLevelT level;
	mixLevelT accumulator;
	logic [levelWidth:0] accNext;

	// 2 dB per step
	function automatic amplitudeT attenToAmplitude(input attenT code);
		amplitudeT amp;
		case (code)
			4'd0:    amp = 8'd255;
			4'd1:    amp = 8'd203;
			4'd2:    amp = 8'd161;
			4'd3:    amp = 8'd128;
			4'd4:    amp = 8'd102;
			4'd5:    amp = 8'd81;
			4'd6:    amp = 8'd64;
			4'd7:    amp = 8'd51;
			4'd8:    amp = 8'd40;
			4'd9:    amp = 8'd32;
			4'd10:   amp = 8'd26;
			4'd11:   amp = 8'd20;
			4'd12:   amp = 8'd16;
			4'd13:   amp = 8'd13;
			4'd14:   amp = 8'd10;
			default: amp = 8'd0;
		endcase
		return amp;
	endfunction

	always_comb begin
		for (int i = 0; i < channelCount; i++) begin
			voiceAmp[i] = attenToAmplitude(attens[i*attenWidth +: attenWidth]);
		end
	end

	// Only voices in their high half contribute
	always_comb begin
		levelSum = '0;
		for (int i = 0; i < channelCount; i++) begin
			if (squares[i]) begin
				levelSum = levelSum + mixLevelT'(voiceAmp[i]);
			end
		end
	end

	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			level <= '0;
		end else begin
			level <= levelSum;
		end
	end

	// First-order sigma-delta
	// the carry out is the pulse density
	assign accNext = {1'b0, accumulator} + {1'b0, level};

	always_ff @(posedge PIXELCLK) begin
		if (reset) begin
			accumulator <= '0;
			pwm <= 1'b0;
		end else begin
			accumulator <= accNext[levelWidth-1:0];
			pwm <= accNext[levelWidth];
		end
	end

endmodule

//--- source/soundSubsystem.sv
module soundSubsystem #(
	parameter int channelCount = 3
) (
	input  logic                PIXELCLK,
	input  logic                reset,
	input  logic                procEn,
	input  logic                latchWrite,
	input  soundPkg::latchAddrT latchAddress,
	input  logic                latchData,
	input  soundPkg::busByteT   portA,
	output logic                pwm
);

	import soundPkg::*;

	localparam int periodWidth = $bits(tonePeriodT);

	logic toneTick;
	logic [channelCount*periodWidth-1:0] periods;
	logic [channelCount*$bits(attenT)-1:0] attens;
	logic [channelCount-1:0] squares;

	// System latch and register file
	psgBusInterface #(
		.channelCount(channelCount)
	) psgBusInterface_inst (
		.PIXELCLK(PIXELCLK),
		.reset(reset),
		.procEn(procEn),
		.latchWrite(latchWrite),
		.latchAddress(latchAddress),
		.latchData(latchData),
		.portA(portA),
		.toneTick(toneTick),
		.periods(periods),
		.attens(attens)
	);

	// One square-wave voice per channel
	for (genvar i = 0; i < channelCount; i++) begin : voiceGen
		toneChannel toneChannel_inst (
			.PIXELCLK(PIXELCLK),
			.reset(reset),
			.toneTick(toneTick),
			.period(periods[i*periodWidth +: periodWidth]),
			.square(squares[i])
		);
	end

	psgMixer #(
		.channelCount(channelCount)
	) psgMixer_inst (
		.PIXELCLK(PIXELCLK),
		.reset(reset),
		.squares(squares),
		.attens(attens),
		.pwm(pwm)
	);

endmodule

//--- dv/soundTests.svh
`ifndef SOUND_TESTS_SVH
`define SOUND_TESTS_SVH

// Linear amplitude for each attenuation code
int ampTable [16] = '{255, 203, 161, 128, 102, 81, 64, 51, 40, 32, 26, 20, 16, 13, 10, 0};

// Latch byte with the low nibble and data byte with the high six bits
task automatic setTone(input logic [1:0] channel, input tonePeriodT period);
	writeSound({1'b1, channel, 1'b0, period[3:0]});
	writeSound({2'b00, period[9:4]});
endtask

task automatic setAtten(input logic [1:0] channel, input attenT code);
	writeSound({1'b1, channel, 1'b1, code});
endtask

function automatic int tolerance(input int expected);
	return (expected / 50 > 2) ? expected / 50 : 2;
endfunction

// Zero period behaves like one
function automatic int halfTicks(input tonePeriodT period);
	return (period == '0) ? 1 : int'(period);
endfunction

task automatic silenceAfterReset();
	int ones;
	countOnes(4096, ones);
	assert (ones == 0) else reportFailure($sformatf("pwm high %0d times after reset", ones));
endtask

task automatic writeGating();
	int ones;
	portA = 8'h90;
	for (int a = 1; a < 8; a++) begin
		writeLatch(latchAddrT'(a), 1'b0);
	end
	// Strobe while the processor is held off
	enLevel = 1'b0;
	writeLatch(3'd0, 1'b0);
	enLevel = 1'b1;
	// Bit 0 set twice without a falling edge
	writeLatch(3'd0, 1'b1);
	writeLatch(3'd0, 1'b1);
	// Noise channel volume
	writeSound(8'hF0);
	countOnes(2048, ones);
	assert (ones == 0) else reportFailure($sformatf("gated writes gave %0d highs", ones));
	setTone(2'd0, 10'd4);
	setAtten(2'd0, 4'd0);
	countOnes(1024, ones);
	assert (ones > 0) else reportFailure("pwm silent after a proper write");
endtask

task automatic amplitudeByAtten();
	attenT code;
	int ones;
	int expected;
	rngState = xorshift32(rngState);
	code = rngState[3:0];
	setTone(2'd0, 10'd64);
	setAtten(2'd0, code);
	repeat (4096) @(negedge PIXELCLK);
	// 64 full periods of 2048 cycles each
	countOnes(64 * 2048, ones);
	expected = 64 * ampTable[code];
	assert (ones >= expected - tolerance(expected) && ones <= expected + tolerance(expected))
	else reportFailure($sformatf("atten %0d: %0d highs, expected %0d", code, ones, expected));
endtask

task automatic toneFrequency();
	tonePeriodT period;
	int longest;
	int target;
	rngState = xorshift32(rngState);
	period = rngState[9:0];
	setTone(2'd0, period);
	setAtten(2'd0, 4'd0);
	repeat (2048) @(negedge PIXELCLK);
	target = 16 * halfTicks(period);
	longestLow(4 * target + 64, longest);
	assert (longest >= target - 5 && longest <= target + 8)
	else reportFailure($sformatf("period %0d: low run %0d, expected %0d", period, longest, target));
endtask

task automatic prescaledFrequency();
	tonePeriodT period;
	int longest;
	int target;
	rngState = xorshift32(rngState);
	period = rngState[9:0];
	setTone(2'd0, period);
	halfRate = 1'b1;
	// Old count may still need up to 1023 slow ticks
	repeat (32 * 1024 + 64) @(negedge PIXELCLK);
	target = 32 * halfTicks(period);
	longestLow(4 * target + 128, longest);
	halfRate = 1'b0;
	assert (longest >= target - 10 && longest <= target + 16)
	else reportFailure($sformatf("half rate, period %0d: low run %0d, expected %0d",
		period, longest, target));
endtask

task automatic voiceMixing();
	tonePeriodT period;
	attenT code;
	int ampSum;
	int window;
	int ones;
	int expected;
	rngState = xorshift32(rngState);
	period = rngState[9:0];
	ampSum = 0;
	for (int ch = 0; ch < 3; ch++) begin
		rngState = xorshift32(rngState);
		code = rngState[3:0];
		ampSum += ampTable[code];
		setTone(2'(ch), period);
		setAtten(2'(ch), code);
	end
	repeat (16 * 1024 + 256) @(negedge PIXELCLK);
	// 16 full periods with each voice high for half of them
	window = 16 * 32 * halfTicks(period);
	countOnes(window, ones);
	expected = window * ampSum / 2048;
	assert (ones >= expected - tolerance(expected) && ones <= expected + tolerance(expected))
	else reportFailure($sformatf("mix sum %0d: %0d highs, expected %0d", ampSum, ones, expected));
endtask

`endif

//--- dv/soundSubsystemTb.sv
module soundSubsystemTb;

	import soundPkg::*;

	logic PIXELCLK;
	logic reset;
	logic procEn;
	logic latchWrite;
	latchAddrT latchAddress;
	logic latchData;
	busByteT portA;
	logic pwm;

	// Processor enable at full rate or every second cycle
	logic enLevel;
	logic halfRate;
	logic enPhase = 1'b0;
	logic [31:0] rngState;

	assign procEn = halfRate ? enPhase : enLevel;

	soundSubsystem #(
		.channelCount(3)
	) soundSubsystem_inst (
		.PIXELCLK(PIXELCLK),
		.reset(reset),
		.procEn(procEn),
		.latchWrite(latchWrite),
		.latchAddress(latchAddress),
		.latchData(latchData),
		.portA(portA),
		.pwm(pwm)
	);

	initial begin
		PIXELCLK = 1'b0;
		forever #4 PIXELCLK = ~PIXELCLK;
	end

	always @(negedge PIXELCLK) begin
		enPhase <= ~enPhase;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] value);
		logic [31:0] x;
		x = value;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic reportFailure(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic timeoutFailure(input string what);
		$display("Timed out at time %0t while waiting for %s", $time, what);
		$display("Verification failed");
		$fatal(1, "stopping after timeout");
	endtask

	// One strobe cycle from falling edge to falling edge
	task automatic writeLatch(input latchAddrT addr, input logic bitValue);
		latchAddress = addr;
		latchData = bitValue;
		latchWrite = 1'b1;
		@(negedge PIXELCLK);
		latchWrite = 1'b0;
	endtask

	// Falling edge of latch bit 0 is the sound write
	task automatic writeSound(input busByteT value);
		portA = value;
		writeLatch(3'd0, 1'b0);
		writeLatch(3'd0, 1'b1);
		@(negedge PIXELCLK);
	endtask

	task automatic countOnes(input int cycles, output int ones);
		ones = 0;
		repeat (cycles) begin
			@(negedge PIXELCLK);
			if (pwm) begin
				ones++;
			end
		end
	endtask

	task automatic longestLow(input int window, output int longest);
		int run;
		int waited;
		longest = 0;
		run = 0;
		waited = 0;
		// Start right after a low run ends
		while (!pwm && waited < 40000) begin
			@(negedge PIXELCLK);
			waited++;
		end
		if (!pwm) begin
			timeoutFailure("pwm to go high");
		end else begin
			repeat (window) begin
				@(negedge PIXELCLK);
				if (pwm) begin
					run = 0;
				end else begin
					run++;
					if (run > longest) begin
						longest = run;
					end
				end
			end
		end
	endtask

	`include "soundTests.svh"

	initial begin
		reset = 1'b1;
		latchWrite = 1'b0;
		latchAddress = '0;
		latchData = 1'b0;
		portA = '0;
		enLevel = 1'b1;
		halfRate = 1'b0;
		rngState = 32'h6576f814;
		repeat (10) @(posedge PIXELCLK);
		@(negedge PIXELCLK);
		reset = 1'b0;
		silenceAfterReset();
		writeGating();
		amplitudeByAtten();
		toneFrequency();
		prescaledFrequency();
		voiceMixing();
		$display("Verification passed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+dv
common/soundPkg.sv
psg/psgBusInterface.sv
psg/toneChannel.sv
psg/psgMixer.sv
source/soundSubsystem.sv
dv/soundSubsystemTb.sv

//--- Makefile
# Verilator build and run of the sound subsystem testbench

VERILATOR ?= verilator
TOP ?= soundSubsystemTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) dv/soundTests.svh
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Verification passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
